/* hdl/acc_pkg.sv */
// shared widths, register map and types for the accumulator kernel; import where needed
package acc_pkg;

  // stream and register word
  localparam int WORD_W = 32;
  // one signed operand lane, LANES of them per word
  localparam int LANE_W = 8;
  localparam int LANES  = 4;
  // ci and co counts
  localparam int CNT_W  = 16;

  typedef logic        [WORD_W-1:0]   word_t;
  typedef logic signed [LANE_W-1:0]   lane_t;
  // product of two lanes is 16 bits, a sum of four needs two more
  typedef logic signed [2*LANE_W+1:0] dot_t;
  // result wraps at 32 bits
  typedef logic signed [WORD_W-1:0]   acc_t;
  typedef logic        [CNT_W-1:0]    count_t;
  typedef logic        [0:0]          reg_addr_t;

  // register write port map
  localparam reg_addr_t REG_CI = 1'b0;
  localparam reg_addr_t REG_CO = 1'b1;

  // job control states
  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } ctrl_state_t;

endpackage

/* hdl/acc_ctrl.sv */
// job control for the accumulator kernel: config registers, start/done handshake, run enable
`timescale 1ns/1ns

module acc_ctrl import acc_pkg::*; (
  input  logic      ap_clk,
  input  logic      ap_rst_n,
  input  logic      cfg_wr_en,
  input  reg_addr_t cfg_wr_addr,
  input  word_t     cfg_wr_data,
  input  logic      ap_start,
  input  logic      ofm_valid,
  input  logic      ofm_ready,
  output logic      ap_ready,
  output logic      ap_idle,
  output logic      ap_done,
  output logic      run,
  output count_t    job_ci
);

  ctrl_state_t state;
  count_t      cfg_ci;
  count_t      cfg_co;
  count_t      job_co;
  count_t      out_cnt;
  logic        start_acc;
  logic        ofm_beat;
  logic        last_out;

  assign ap_idle   = (state == ST_IDLE);
  assign ap_ready  = (state == ST_IDLE);
  assign run       = (state == ST_RUN);
  assign start_acc = ap_start & ap_ready;
  assign ofm_beat  = ofm_valid & ofm_ready & run;
  assign last_out  = ofm_beat & (out_cnt == job_co - count_t'(1));

  // host side registers, only the low count bits are kept
  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      cfg_ci <= '0;
      cfg_co <= '0;
    end else if (cfg_wr_en) begin
      if (cfg_wr_addr == REG_CI) begin
        cfg_ci <= cfg_wr_data[CNT_W-1:0];
      end else if (cfg_wr_addr == REG_CO) begin
        cfg_co <= cfg_wr_data[CNT_W-1:0];
      end
    end
  end

  // working copy, frozen for the whole job
  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      job_ci <= '0;
      job_co <= '0;
    end else if (start_acc) begin
      job_ci <= cfg_ci;
      job_co <= cfg_co;
    end
  end

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      state   <= ST_IDLE;
      out_cnt <= '0;
      ap_done <= 1'b0;
    end else begin
      ap_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          out_cnt <= '0;
          if (start_acc) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (last_out) begin
            // idle and done appear together on the next cycle
            state   <= ST_IDLE;
            ap_done <= 1'b1;
          end else if (ofm_beat) begin
            out_cnt <= out_cnt + count_t'(1);
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // a job with a zero count would never finish
  a_cfg_nonzero: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    start_acc |=> (job_ci != '0) && (job_co != '0))
    else $error("job started with ci or co equal to zero");

  a_done_pulse: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ap_done |=> !ap_done)
    else $error("ap_done held for more than one cycle");

endmodule

/* hdl/dot4_stage.sv */
// input side: joins the ifm and wgt streams and registers their four-lane signed dot product
`timescale 1ns/1ns

module dot4_stage import acc_pkg::*; (
  input  logic  ap_clk,
  input  logic  ap_rst_n,
  input  logic  run,
  input  logic  ifm_valid,
  input  word_t ifm_data,
  output logic  ifm_ready,
  input  logic  wgt_valid,
  input  word_t wgt_data,
  output logic  wgt_ready,
  output logic  dot_valid,
  input  logic  dot_ready,
  output dot_t  dot_data
);

  logic take;

  // lane k sits in bits 8k+7 down to 8k
  function automatic dot_t dot4(input word_t a, input word_t b);
    dot_t  sum;
    lane_t la;
    lane_t lb;
    sum = '0;
    for (int k = 0; k < LANES; k++) begin
      la  = a[k*LANE_W +: LANE_W];
      lb  = b[k*LANE_W +: LANE_W];
      sum = sum + la * lb;
    end
    return sum;
  endfunction

  // both streams move only as a pair
  assign take      = ifm_valid & wgt_valid & run & (~dot_valid | dot_ready);
  assign ifm_ready = take;
  assign wgt_ready = take;

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      dot_valid <= 1'b0;
    end else if (take) begin
      dot_valid <= 1'b1;
    end else if (dot_ready) begin
      dot_valid <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (take) begin
      dot_data <= dot4(ifm_data, wgt_data);
    end
  end

  // a word waiting for its partner must stay offered unchanged
  a_ifm_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ifm_valid && !ifm_ready |=> ifm_valid && $stable(ifm_data))
    else $error("ifm word dropped or changed before it was accepted");

  a_wgt_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    wgt_valid && !wgt_ready |=> wgt_valid && $stable(wgt_data))
    else $error("wgt word dropped or changed before it was accepted");

endmodule

/* hdl/acc_stage.sv */
// processing part: sums job_ci dot products per output and holds each result until taken
`timescale 1ns/1ns

module acc_stage import acc_pkg::*; (
  input  logic   ap_clk,
  input  logic   ap_rst_n,
  input  logic   dot_valid,
  input  dot_t   dot_data,
  output logic   dot_ready,
  input  count_t job_ci,
  output logic   res_valid,
  input  logic   res_ready,
  output acc_t   res_data
);

  acc_t   sum;
  acc_t   sum_next;
  count_t beat_cnt;
  logic   take;
  logic   last_beat;

  // result register free or draining this cycle
  assign dot_ready = ~res_valid | res_ready;
  assign take      = dot_valid & dot_ready;
  assign last_beat = (beat_cnt == job_ci - count_t'(1));

  // sign extension of the product, wrapping sum
  assign sum_next = sum + acc_t'(dot_data);

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      sum      <= '0;
      beat_cnt <= '0;
    end else if (take) begin
      if (last_beat) begin
        // next group starts from zero while this result waits
        sum      <= '0;
        beat_cnt <= '0;
      end else begin
        sum      <= sum_next;
        beat_cnt <= beat_cnt + count_t'(1);
      end
    end
  end

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      res_valid <= 1'b0;
    end else begin
      if (res_ready) begin
        res_valid <= 1'b0;
      end
      if (take && last_beat) begin
        res_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (take && last_beat) begin
      res_data <= sum_next;
    end
  end

  a_res_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    res_valid && !res_ready |=> res_valid && $stable(res_data))
    else $error("result changed while stalled");

endmodule

/* hdl/ofm_out.sv */
// output side: one-entry register slice that byte-reverses each result onto the ofm stream
`timescale 1ns/1ns

module ofm_out import acc_pkg::*; (
  input  logic  ap_clk,
  input  logic  ap_rst_n,
  input  logic  res_valid,
  input  acc_t  res_data,
  output logic  res_ready,
  output logic  ofm_valid,
  input  logic  ofm_ready,
  output word_t ofm_data
);

  word_t swapped;
  logic  load;

  // byte 0 of the result lands in bits 31:24, as in a little-endian store
  always_comb begin
    for (int i = 0; i < WORD_W/8; i++) begin
      swapped[i*8 +: 8] = res_data[(WORD_W/8-1-i)*8 +: 8];
    end
  end

  assign res_ready = ~ofm_valid | ofm_ready;
  assign load      = res_valid & res_ready;

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      ofm_valid <= 1'b0;
    end else if (load) begin
      ofm_valid <= 1'b1;
    end else if (ofm_ready) begin
      ofm_valid <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (load) begin
      ofm_data <= swapped;
    end
  end

endmodule

/* hdl/krnl_acc.sv */
// top level of the accumulator kernel: connects job control and the three datapath stages
`timescale 1ns/1ns

module krnl_acc import acc_pkg::*; (
  input  logic      ap_clk,
  input  logic      ap_rst_n,
  // host register writes
  input  logic      cfg_wr_en,
  input  reg_addr_t cfg_wr_addr,
  input  word_t     cfg_wr_data,
  // job handshake
  input  logic      ap_start,
  output logic      ap_ready,
  output logic      ap_done,
  output logic      ap_idle,
  // operand streams
  input  logic      ifm_valid,
  output logic      ifm_ready,
  input  word_t     ifm_data,
  input  logic      wgt_valid,
  output logic      wgt_ready,
  input  word_t     wgt_data,
  // result stream
  output logic      ofm_valid,
  input  logic      ofm_ready,
  output word_t     ofm_data
);

  logic   run;
  count_t job_ci;
  logic   dot_valid;
  logic   dot_ready;
  dot_t   dot_data;
  logic   res_valid;
  logic   res_ready;
  acc_t   res_data;

  acc_ctrl u_ctrl (
    .ap_clk      (ap_clk),
    .ap_rst_n    (ap_rst_n),
    .cfg_wr_en   (cfg_wr_en),
    .cfg_wr_addr (cfg_wr_addr),
    .cfg_wr_data (cfg_wr_data),
    .ap_start    (ap_start),
    .ofm_valid   (ofm_valid),
    .ofm_ready   (ofm_ready),
    .ap_ready    (ap_ready),
    .ap_idle     (ap_idle),
    .ap_done     (ap_done),
    .run         (run),
    .job_ci      (job_ci)
  );

  dot4_stage u_dot4 (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .run       (run),
    .ifm_valid (ifm_valid),
    .ifm_data  (ifm_data),
    .ifm_ready (ifm_ready),
    .wgt_valid (wgt_valid),
    .wgt_data  (wgt_data),
    .wgt_ready (wgt_ready),
    .dot_valid (dot_valid),
    .dot_ready (dot_ready),
    .dot_data  (dot_data)
  );

  acc_stage u_acc (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .dot_valid (dot_valid),
    .dot_data  (dot_data),
    .dot_ready (dot_ready),
    .job_ci    (job_ci),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data)
  );

  ofm_out u_ofm (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_ready (res_ready),
    .ofm_valid (ofm_valid),
    .ofm_ready (ofm_ready),
    .ofm_data  (ofm_data)
  );

endmodule

/* testbench/tb_tasks.svh */
// directed tests, handshake helpers and typed compare tasks, included inside tb_krnl_acc
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  string cur_name;
  int    err_base;

  // signed four-lane dot product, lane k in bits 8k+7 down to 8k
  function automatic int lane_dot(input word_t a, input word_t b);
    int s;
    s = 0;
    for (int k = 0; k < 4; k++) begin
      s = s + int'($signed(a[k*8 +: 8])) * int'($signed(b[k*8 +: 8]));
    end
    return s;
  endfunction

  // byte 0 moves to the top, as in a little-endian store
  function automatic word_t byte_rev(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected %08h, actual %08h", cur_name, what, exp, act);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected %b, actual %b", cur_name, what, exp, act);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic check_count(input string what, input count_t exp, input count_t act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic clear_expect();
    exp_q.delete();
    got_base = got_q.size();
  endtask

  task automatic open_test(input string name);
    cur_name  = name;
    err_base  = err_cnt;
    done_base = done_cnt;
    clear_expect();
  endtask

  task automatic close_test();
    if (err_cnt == err_base) begin
      pass_cnt = pass_cnt + 1;
      $display("PASS %s", cur_name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("FAIL %s with %0d errors", cur_name, err_cnt - err_base);
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input word_t data);
    @(posedge ap_clk);
    cfg_wr_en   <= 1'b1;
    cfg_wr_addr <= addr;
    cfg_wr_data <= data;
    @(posedge ap_clk);
    cfg_wr_en <= 1'b0;
  endtask

  // holds ap_start until the edge where ap_ready is also high
  task automatic start_job();
    int   n;
    logic taken;
    n     = 0;
    taken = 1'b0;
    @(posedge ap_clk);
    ap_start <= 1'b1;
    while (!taken && n < 100) begin
      @(posedge ap_clk);
      taken = ap_ready;
      n     = n + 1;
    end
    ap_start <= 1'b0;
    if (!taken) begin
      $display("%s: start was not accepted within 100 cycles", cur_name);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic wait_done(input int limit);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      @(posedge ap_clk);
      seen = ap_done;
      n    = n + 1;
    end
    if (!seen) begin
      $display("%s: ap_done did not arrive within %0d cycles", cur_name, limit);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic push_pair(input word_t a, input word_t b);
    ifm_q.push_back(a);
    wgt_q.push_back(b);
  endtask

  // random operands, one expected word per group of ci pairs
  task automatic queue_job(input int ci, input int co);
    word_t a;
    word_t b;
    int    sum;
    for (int o = 0; o < co; o++) begin
      sum = 0;
      for (int i = 0; i < ci; i++) begin
        a = $random(seed);
        b = $random(seed);
        push_pair(a, b);
        sum = sum + lane_dot(a, b);
      end
      exp_q.push_back(byte_rev(word_t'(sum)));
    end
  endtask

  task automatic compare_results();
    int n;
    n = got_q.size() - got_base;
    check_count("ofm word count", count_t'(exp_q.size()), count_t'(n));
    for (int i = 0; i < exp_q.size() && i < n; i++) begin
      check_word($sformatf("ofm word %0d", i), exp_q[i], got_q[got_base + i]);
    end
  endtask

  task automatic reset_values();
    open_test("reset_values");
    @(posedge ap_clk);
    check_bit("ap_idle", 1'b1, ap_idle);
    check_bit("ap_ready", 1'b1, ap_ready);
    check_bit("ap_done", 1'b0, ap_done);
    check_bit("ofm_valid", 1'b0, ofm_valid);
    check_bit("ifm_ready", 1'b0, ifm_ready);
    check_bit("wgt_ready", 1'b0, wgt_ready);
    close_test();
  endtask

  task automatic single_job();
    word_t a;
    word_t b;
    // lanes 3, -2, 127, -128 against -6, 5, -127, 127
    a = 32'h807f_fe03;
    b = 32'h7f81_05fa;
    open_test("single_job");
    write_reg(REG_CI, 32'd1);
    write_reg(REG_CO, 32'd1);
    push_pair(a, b);
    exp_q.push_back(byte_rev(word_t'(lane_dot(a, b))));
    start_job();
    wait_done(200);
    check_bit("ap_idle at done", 1'b1, ap_idle);
    repeat (4) @(posedge ap_clk);
    check_count("ap_done pulses", 16'd1, count_t'(done_cnt - done_base));
    check_bit("ap_idle after done", 1'b1, ap_idle);
    compare_results();
    close_test();
  endtask

  task automatic multi_job();
    open_test("multi_job");
    write_reg(REG_CI, 32'd3);
    write_reg(REG_CO, 32'd4);
    queue_job(3, 4);
    start_job();
    wait_done(500);
    repeat (4) @(posedge ap_clk);
    check_count("ap_done pulses", 16'd1, count_t'(done_cnt - done_base));
    compare_results();
    close_test();
  endtask

  task automatic backpressure_job();
    open_test("backpressure_job");
    gap_en <= 1'b1;
    bp_en  <= 1'b1;
    write_reg(REG_CI, 32'd5);
    write_reg(REG_CO, 32'd6);
    queue_job(5, 6);
    start_job();
    wait_done(3000);
    repeat (4) @(posedge ap_clk);
    check_count("ap_done pulses", 16'd1, count_t'(done_cnt - done_base));
    compare_results();
    gap_en <= 1'b0;
    bp_en  <= 1'b0;
    close_test();
  endtask

  // new ci and co written while the first job runs apply to the second
  task automatic reconfig_midjob();
    open_test("reconfig_midjob");
    gap_en <= 1'b1;
    write_reg(REG_CI, 32'd2);
    write_reg(REG_CO, 32'd3);
    queue_job(2, 3);
    start_job();
    write_reg(REG_CI, 32'd4);
    write_reg(REG_CO, 32'd1);
    check_bit("ap_idle during job", 1'b0, ap_idle);
    wait_done(2000);
    compare_results();
    clear_expect();
    gap_en <= 1'b0;
    queue_job(4, 1);
    start_job();
    wait_done(500);
    repeat (4) @(posedge ap_clk);
    check_count("ap_done pulses", 16'd2, count_t'(done_cnt - done_base));
    compare_results();
    close_test();
  endtask

`endif

/* testbench/tb_krnl_acc.sv */
// testbench top for the accumulator kernel: clock, reset, stream drivers, monitor, test sequence
`timescale 1ns/1ns

module tb_krnl_acc import acc_pkg::*; ();

  logic      ap_clk = 1'b0;
  logic      ap_rst_n;
  logic      cfg_wr_en;
  reg_addr_t cfg_wr_addr;
  word_t     cfg_wr_data;
  logic      ap_start;
  logic      ap_ready;
  logic      ap_done;
  logic      ap_idle;
  logic      ifm_valid = 1'b0;
  logic      ifm_ready;
  word_t     ifm_data  = '0;
  logic      wgt_valid = 1'b0;
  logic      wgt_ready;
  word_t     wgt_data  = '0;
  logic      ofm_valid;
  logic      ofm_ready = 1'b1;
  word_t     ofm_data;

  integer seed = 32'h6e1f_0613;

  // operand words still to send, expected and received ofm words
  word_t ifm_q[$];
  word_t wgt_q[$];
  word_t exp_q[$];
  word_t got_q[$];
  int    got_base = 0;
  int    done_cnt = 0;
  int    done_base = 0;

  // valid gaps on the operand streams, random ofm_ready
  logic  gap_en = 1'b0;
  logic  bp_en  = 1'b0;

  int    err_cnt  = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;
  int    rnd_i;
  int    rnd_w;
  int    rnd_o;

  krnl_acc dut (.*);

  always #4 ap_clk = ~ap_clk;

  // operand drivers, each word held with valid until accepted
  always @(posedge ap_clk) begin
    if (ap_rst_n) begin
      rnd_i = $random(seed);
      rnd_w = $random(seed);
      rnd_o = $random(seed);
      if (ifm_valid && ifm_ready) begin
        void'(ifm_q.pop_front());
      end
      if (!ifm_valid || ifm_ready) begin
        if (ifm_q.size() > 0 && (!gap_en || rnd_i[0])) begin
          ifm_valid <= 1'b1;
          ifm_data  <= ifm_q[0];
        end else begin
          ifm_valid <= 1'b0;
        end
      end
      if (wgt_valid && wgt_ready) begin
        void'(wgt_q.pop_front());
      end
      if (!wgt_valid || wgt_ready) begin
        if (wgt_q.size() > 0 && (!gap_en || rnd_w[0])) begin
          wgt_valid <= 1'b1;
          wgt_data  <= wgt_q[0];
        end else begin
          wgt_valid <= 1'b0;
        end
      end
      ofm_ready <= bp_en ? rnd_o[0] : 1'b1;
    end
  end

  // ofm words and done pulses as the DUT produces them
  always @(posedge ap_clk) begin
    if (ap_rst_n) begin
      if (ofm_valid && ofm_ready) begin
        got_q.push_back(ofm_data);
      end
      if (ap_done) begin
        done_cnt = done_cnt + 1;
      end
    end
  end

  `include "tb_tasks.svh"

  initial begin
    ap_rst_n    = 1'b0;
    cfg_wr_en   = 1'b0;
    cfg_wr_addr = REG_CI;
    cfg_wr_data = '0;
    ap_start    = 1'b0;
    repeat (16) @(posedge ap_clk);
    ap_rst_n <= 1'b1;
    reset_values();
    single_job();
    multi_job();
    backpressure_job();
    reconfig_midjob();
    $display("summary: %0d passing, %0d failing", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+testbench
hdl/acc_pkg.sv
hdl/acc_ctrl.sv
hdl/dot4_stage.sv
hdl/acc_stage.sv
hdl/ofm_out.sv
hdl/krnl_acc.sv
testbench/tb_krnl_acc.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_krnl_acc \
  -f project.f

out="$(./obj_dir/Vtb_krnl_acc)"
printf '%s\n' "$out"

# nonzero exit status when the pass line is missing
printf '%s\n' "$out" | grep -q "All tests passed"
